/* bridge_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types and constants for the serial SRAM debug bridge
// register map, command codes, status byte, SRAM address width
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package bridge_pkg;

    // configuration register map, as sent in the address byte
    typedef enum logic [7:0] {
        REG_STREAM   = 8'h00,   // raw stream bytes during W
        REG_GPIO     = 8'h01,
        REG_ADDR_HI  = 8'h02,   // addr bits 18..16
        REG_ADDR_MID = 8'h03,   // addr bits 15..8
        REG_ADDR_LO  = 8'h04,   // addr bits 7..0
        REG_LEN      = 8'h05,
        REG_CMD      = 8'h06
    } reg_addr_e;

    // command codes, ascii letters
    typedef enum logic [7:0] {
        CMD_IDLE   = 8'h00,
        CMD_WRITE  = 8'h57,     // 'W'
        CMD_READ   = 8'h52,     // 'R'
        CMD_STATUS = 8'h53      // 'S'
    } cmd_e;

    // byte returned by the S command
    localparam logic [7:0] STATUS_CHAR = 8'h53;

    // external async SRAM address width
    localparam int SRAM_AW = 19;

endpackage

`default_nettype wire

/* logic/acia_rx.sv */
////////////////////////////////////////////////////////////////////////////
// UART receiver, 8N1, start bit checked at mid-bit, byte-valid pulse
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module acia_rx #(
    parameter int BIT_CNT = 16              // clocks per serial bit
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,                  // serial in, idle high
    output logic [7:0] rx_dat,
    output logic       rx_valid             // one cycle, at stop bit sample
);

    localparam int CW = $clog2(BIT_CNT);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e     state;
    logic          rx_s1;                   // synchronizer stages
    logic          rx_s2;
    logic          rx_d;                    // for falling edge detect
    logic [CW-1:0] cnt;                     // bit period down counter
    logic [2:0]    nbit;                    // data bit index
    logic [7:0]    shreg;

    assign rx_dat = shreg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_d     <= 1'b1;
            state    <= RX_IDLE;
            cnt      <= '0;
            nbit     <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_s1    <= rx;
            rx_s2    <= rx_s1;
            rx_d     <= rx_s2;
            rx_valid <= 1'b0;
            if (state != RX_IDLE && cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    if (rx_d && !rx_s2) begin
                        state <= RX_START;
                        cnt   <= CW'(BIT_CNT / 2 - 1);   // half a bit to midpoint
                    end
                end
                RX_START: begin
                    if (cnt == '0) begin
                        // glitch shorter than half a bit goes back to idle
                        state <= rx_s2 ? RX_IDLE : RX_DATA;
                        cnt   <= CW'(BIT_CNT - 1);
                        nbit  <= '0;
                    end
                end
                RX_DATA: begin
                    if (cnt == '0) begin
                        cnt  <= CW'(BIT_CNT - 1);
                        nbit <= nbit + 1'b1;
                        if (nbit == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (cnt == '0) begin
                        rx_valid <= rx_s2;      // drop byte on bad stop bit
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == '0) begin
            shreg <= {rx_s2, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

/* logic/uart_ctl.sv */
////////////////////////////////////////////////////////////////////////////
// receive framing: address/data pairs to register writes, raw stream mode
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module uart_ctl import bridge_pkg::*; #(
    parameter int BIT_CNT = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    input  logic       raw,             // every byte is stream data
    output logic       cfg_we,
    output logic [7:0] cfg_addr,
    output logic [7:0] cfg_dat
);

    logic [7:0] rx_dat;
    logic       rx_valid;
    logic       phase;                  // 0 address byte, 1 data byte
    logic [7:0] addr_lat;

    acia_rx #(
        .BIT_CNT (BIT_CNT)
    ) u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_dat   (rx_dat),
        .rx_valid (rx_valid)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase  <= 1'b0;
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= 1'b0;
            if (raw) begin
                phase  <= 1'b0;         // resync pairs after the stream
                cfg_we <= rx_valid;
            end else if (rx_valid) begin
                phase  <= ~phase;
                cfg_we <= phase;        // strobe on the data byte
            end
        end
    end

    // address latch and write payload
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (raw) begin
                cfg_addr <= REG_STREAM;
                cfg_dat  <= rx_dat;
            end else if (!phase) begin
                addr_lat <= rx_dat;
            end else begin
                cfg_addr <= addr_lat;
                cfg_dat  <= rx_dat;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/acia_tx.sv */
////////////////////////////////////////////////////////////////////////////
// UART transmitter, 8N1, busy from start pulse to end of stop bit
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module acia_tx #(
    parameter int BIT_CNT = 16              // clocks per serial bit
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_dat,
    input  logic       tx_start,            // one cycle, ignored while busy
    output logic       tx,
    output logic       tx_busy
);

    localparam int CW = $clog2(BIT_CNT);

    logic [9:0]    frame;                   // stop, data msb..lsb, start
    logic [CW-1:0] cnt;
    logic [3:0]    nbit;                    // frame bit index, 0..9

    // line is the lsb of the frame, all ones when idle
    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame   <= '1;
            cnt     <= '0;
            nbit    <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame   <= {1'b1, tx_dat, 1'b0};
                cnt     <= CW'(BIT_CNT - 1);
                nbit    <= '0;
                tx_busy <= 1'b1;
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            cnt   <= CW'(BIT_CNT - 1);
            frame <= {1'b1, frame[9:1]};    // shift in idle level
            if (nbit == 4'd9) begin
                tx_busy <= 1'b0;            // stop bit done
            end else begin
                nbit <= nbit + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cmd_engine.sv */
////////////////////////////////////////////////////////////////////////////
// config registers, gpio, SRAM address and length counters
// sequencing of the W, R and S commands
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module cmd_engine import bridge_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_we,
    input  logic [7:0]         cfg_addr,
    input  logic [7:0]         cfg_dat,
    input  logic               tx_busy,
    input  logic [7:0]         sram_din,
    output logic               raw,
    output logic [7:0]         gpio_o,
    output logic [SRAM_AW-1:0] sram_addr,
    output logic [7:0]         sram_dout,
    output logic               sram_we,
    output logic               sram_oe,
    output logic [7:0]         tx_dat,
    output logic               tx_start
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,                           // sram_oe high, data captured
        RD_START                            // tx_start high
    } rd_state_e;

    cmd_e               cmd;
    rd_state_e          rd_state;
    logic [SRAM_AW-1:0] addr;
    logic [7:0]         len;                // bytes left in the command

    // unknown command codes leave the engine idle
    function automatic cmd_e decode_cmd(input logic [7:0] code);
        case (code)
            CMD_WRITE, CMD_READ, CMD_STATUS: return cmd_e'(code);
            default: return CMD_IDLE;
        endcase
    endfunction

    assign raw       = (cmd == CMD_WRITE);
    assign sram_addr = addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd      <= CMD_IDLE;
            rd_state <= RD_IDLE;
            gpio_o   <= '0;
            addr     <= '0;
            len      <= '0;
            sram_we  <= 1'b0;
            sram_oe  <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            sram_we  <= 1'b0;
            sram_oe  <= 1'b0;
            tx_start <= 1'b0;
            case (cmd)
                CMD_IDLE: begin
                    if (cfg_we) begin
                        case (cfg_addr)
                            REG_GPIO:     gpio_o <= cfg_dat;
                            REG_ADDR_HI:  addr[SRAM_AW-1:16] <= cfg_dat[SRAM_AW-17:0];
                            REG_ADDR_MID: addr[15:8] <= cfg_dat;
                            REG_ADDR_LO:  addr[7:0] <= cfg_dat;
                            REG_LEN:      len <= cfg_dat;
                            REG_CMD: begin
                                if (len != '0) begin    // zero length stays idle
                                    cmd <= decode_cmd(cfg_dat);
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                CMD_WRITE: begin
                    if (cfg_we && cfg_addr == REG_STREAM) begin
                        sram_we <= 1'b1;
                    end
                    if (sram_we) begin              // step after the write cycle
                        addr <= addr + 1'b1;
                        len  <= len - 1'b1;
                        if (len == 8'd1) begin
                            cmd <= CMD_IDLE;
                        end
                    end
                end
                CMD_READ, CMD_STATUS: begin
                    case (rd_state)
                        RD_IDLE: begin
                            if (!tx_busy) begin
                                sram_oe  <= (cmd == CMD_READ);
                                rd_state <= RD_FETCH;
                            end
                        end
                        RD_FETCH: begin
                            tx_start <= 1'b1;
                            rd_state <= RD_START;
                        end
                        default: begin
                            // tx_busy goes high next cycle
                            if (cmd == CMD_READ) begin
                                addr <= addr + 1'b1;
                            end
                            len      <= len - 1'b1;
                            rd_state <= RD_IDLE;
                            if (len == 8'd1) begin
                                cmd <= CMD_IDLE;
                            end
                        end
                    endcase
                end
                default: cmd <= CMD_IDLE;
            endcase
        end
    end

    // write data and transmit byte
    always_ff @(posedge clk) begin
        if (cmd == CMD_WRITE && cfg_we) begin
            sram_dout <= cfg_dat;
        end
        if (rd_state == RD_FETCH) begin
            tx_dat <= (cmd == CMD_READ) ? sram_din : STATUS_CHAR;
        end
    end

endmodule

`default_nettype wire

/* logic/sram_bridge.sv */
////////////////////////////////////////////////////////////////////////////
// top level of the UART to async SRAM debug bridge
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module sram_bridge import bridge_pkg::*; #(
    parameter int CLK_FREQ = 10_000_000,    // Hz
    parameter int BAUD     = 625_000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx,
    output logic               tx,
    output logic [7:0]         gpio_o,
    output logic [SRAM_AW-1:0] sram_addr,
    output logic [7:0]         sram_dout,
    input  logic [7:0]         sram_din,
    output logic               sram_we,
    output logic               sram_oe
);

    // clocks per bit, rounded
    localparam int BIT_CNT = (CLK_FREQ + BAUD / 2) / BAUD;

    logic       raw;
    logic       cfg_we;
    logic [7:0] cfg_addr;
    logic [7:0] cfg_dat;
    logic [7:0] tx_dat;
    logic       tx_start;
    logic       tx_busy;

    uart_ctl #(
        .BIT_CNT (BIT_CNT)
    ) u_ctl (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .raw      (raw),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_dat  (cfg_dat)
    );

    cmd_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_dat   (cfg_dat),
        .tx_busy   (tx_busy),
        .sram_din  (sram_din),
        .raw       (raw),
        .gpio_o    (gpio_o),
        .sram_addr (sram_addr),
        .sram_dout (sram_dout),
        .sram_we   (sram_we),
        .sram_oe   (sram_oe),
        .tx_dat    (tx_dat),
        .tx_start  (tx_start)
    );

    acia_tx #(
        .BIT_CNT (BIT_CNT)
    ) u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_dat   (tx_dat),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* dv/sram_bridge_asserts.sv */
////////////////////////////////////////////////////////////////////////////
// concurrent checks on SRAM strobes, tx start pulse and reset state
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module sram_bridge_asserts import bridge_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx,
    input  logic       sram_we,
    input  logic       sram_oe,
    input  logic       tx_start,
    input  logic       tx_busy,
    input  logic [7:0] cmd                  // engine command register
);
    timeunit 1ns;
    timeprecision 1ps;

    int err_cnt = 0;                        // watched by the testbench

    // write and read strobes are exclusive
    we_oe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(sram_we && sram_oe))
        else begin
            $error("sram_we and sram_oe high in the same cycle");
            err_cnt = err_cnt + 1;
        end

    // engine only starts the transmitter when it is free
    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy)
        else begin
            $error("tx_start pulsed while tx_busy was high");
            err_cnt = err_cnt + 1;
        end

    // reset values, seen from the second reset edge on
    reset_values: assert property (@(posedge clk)
        $past(!rst_n) |-> tx && !sram_we && !sram_oe && !tx_start)
        else begin
            $error("tx or a strobe not at its reset value during reset");
            err_cnt = err_cnt + 1;
        end

    // first cycle after reset release is still quiet
    after_reset: assert property (@(posedge clk)
        rst_n && $past(!rst_n) |=> tx && !sram_we && !sram_oe)
        else begin
            $error("tx or a strobe active in the cycle after reset");
            err_cnt = err_cnt + 1;
        end

    // SRAM writes only happen inside a W command
    we_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        sram_we |-> cmd == CMD_WRITE)
        else begin
            $error("sram_we outside of a write command");
            err_cnt = err_cnt + 1;
        end

endmodule

bind sram_bridge sram_bridge_asserts u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx       (tx),
    .sram_we  (sram_we),
    .sram_oe  (sram_oe),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .cmd      (u_engine.cmd)
);

`default_nettype wire

/* dv/sram_bridge_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the UART to SRAM bridge: SRAM model, UART tasks, scenarios
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module sram_bridge_tb import bridge_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_FREQ      = 10_000_000;
    localparam int BAUD          = 625_000;
    localparam int BIT_CLKS      = CLK_FREQ / BAUD;   // 16 clocks per bit
    localparam int START_TIMEOUT = 1000;              // cycles to wait for a start bit
    localparam int WRITE_TIMEOUT = 400;

    logic               clk;
    logic               rst_n;
    logic               rx;
    logic               tx;
    logic [7:0]         gpio_o;
    logic [SRAM_AW-1:0] sram_addr;
    logic [7:0]         sram_dout;
    logic [7:0]         sram_din;
    logic               sram_we;
    logic               sram_oe;

    logic [7:0]         mem [0:511];                  // low 9 address bits only
    logic [SRAM_AW-1:0] wr_addr_q [$];                // full address of every write
    logic [31:0]        seed;

    sram_bridge #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD     (BAUD)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .tx        (tx),
        .gpio_o    (gpio_o),
        .sram_addr (sram_addr),
        .sram_dout (sram_dout),
        .sram_din  (sram_din),
        .sram_we   (sram_we),
        .sram_oe   (sram_oe)
    );

    always #50 clk = ~clk;

    // async SRAM, reads are combinational
    always @(posedge clk) begin
        if (sram_we) begin
            mem[sram_addr[8:0]] <= sram_dout;
            wr_addr_q.push_back(sram_addr);
        end
    end
    assign sram_din = sram_oe ? mem[sram_addr[8:0]] : 8'hxx;   // data only while enabled

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_byte(output logic [7:0] b);
        seed = lcg_step(seed);
        b    = seed[23:16];                           // upper bits mix best
    endtask

    // one 8N1 frame on rx, lsb first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    task automatic send_pair(input logic [7:0] addr, input logic [7:0] dat);
        send_byte(addr);
        send_byte(dat);
    endtask

    // returns at the middle of the stop bit
    task automatic recv_byte(output logic [7:0] b);
        int wait_cnt;
        wait_cnt = 0;
        while (tx !== 1'b0) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > START_TIMEOUT) begin
                fail_run("no start bit appeared on tx");
            end
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            fail_run("start bit on tx shorter than half a bit");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        if (tx !== 1'b1) begin
            fail_run("stop bit on tx was low");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                fail_run("unexpected start bit on tx");
            end
        end
    endtask

    task automatic wait_writes(input int n);
        int wait_cnt;
        wait_cnt = 0;
        while (wr_addr_q.size() < n) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > WRITE_TIMEOUT) begin
                fail_run("stream bytes did not reach the SRAM");
            end
        end
    endtask

    always @(negedge clk) begin
        if (dut0.u_chk.err_cnt != 0) begin
            fail_run("a concurrent assertion failed");
        end
    end

    initial begin
        logic [7:0] gpio_val;
        logic [7:0] got;
        logic [7:0] wdata [4];
        clk   = 1'b0;
        rst_n = 1'b0;
        rx    = 1'b1;
        seed  = 32'hffb724c3;
        for (int i = 0; i < 512; i++) begin
            mem[i] = 8'(i * 37) ^ 8'(i >> 1);
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_eq("gpio_o", gpio_o, 32'h0);
        check_eq("tx", tx, 32'h1);
        check_eq("sram_we", sram_we, 32'h0);
        check_eq("sram_oe", sram_oe, 32'h0);

        next_byte(gpio_val);
        send_pair(REG_GPIO, gpio_val);
        check_eq("gpio_o", gpio_o, gpio_val);

        // stream write across the bit 16 carry
        send_pair(REG_ADDR_HI, 8'h00);
        send_pair(REG_ADDR_MID, 8'hff);
        send_pair(REG_ADDR_LO, 8'hfe);
        send_pair(REG_LEN, 8'd4);
        send_pair(REG_CMD, CMD_WRITE);
        for (int i = 0; i < 4; i++) begin
            next_byte(wdata[i]);
            send_byte(wdata[i]);
        end
        wait_writes(4);
        for (int i = 0; i < 4; i++) begin
            check_eq("sram_addr", wr_addr_q[i], 32'h0fffe + i);
            check_eq("sram_dout", mem[9'(32'h0fffe + i)], wdata[i]);
        end

        // read back, a gpio pair sent meanwhile is dropped
        send_pair(REG_ADDR_HI, 8'h00);
        send_pair(REG_ADDR_MID, 8'hff);
        send_pair(REG_ADDR_LO, 8'hfe);
        send_pair(REG_LEN, 8'd4);
        fork
            begin
                send_pair(REG_CMD, CMD_READ);
                send_pair(REG_GPIO, ~gpio_val);
            end
            for (int i = 0; i < 4; i++) begin
                recv_byte(got);
                check_eq("tx", got, wdata[i]);
            end
        join
        check_eq("gpio_o", gpio_o, gpio_val);

        send_pair(REG_LEN, 8'd3);
        fork
            send_pair(REG_CMD, CMD_STATUS);
            for (int i = 0; i < 3; i++) begin
                recv_byte(got);
                check_eq("tx", got, STATUS_CHAR);
            end
        join
        expect_quiet(20 * BIT_CLKS);

        // length is now zero, read must not start
        fork
            send_pair(REG_CMD, CMD_READ);
            expect_quiet(40 * BIT_CLKS);
        join
        next_byte(gpio_val);
        send_pair(REG_GPIO, gpio_val);
        check_eq("gpio_o", gpio_o, gpio_val);

        if (dut0.u_chk.err_cnt == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("a concurrent assertion failed");
        end
    end

endmodule

`default_nettype wire

/* sram_bridge.f */
bridge_pkg.sv
logic/acia_rx.sv
logic/uart_ctl.sv
logic/acia_tx.sv
logic/cmd_engine.sv
logic/sram_bridge.sv
dv/sram_bridge_asserts.sv
dv/sram_bridge_tb.sv
